//--- compile.f
design/cache_pkg.sv
design/mem_pkg.sv
design/dcache_ctrl.sv
design/main_cache.sv
design/victim_cache.sv
design/mshr_table.sv
design/dcache.sv
sim/dcache_tb.sv

//--- sim/dcache_tb.sv
`default_nettype none

module dcache_tb
    import cache_pkg::*;
    import mem_pkg::*;
;

    localparam int window_bytes = 4096;                      // 16x the main cache, forces evictions
    localparam int window_lines = window_bytes / block_bytes;
    localparam int n_ops        = 3000;                      // operations in one run
    localparam int n_sweep_ops  = window_bytes / 4;          // final word sweep of the window
    localparam int max_cycles   = n_ops * 40;

    typedef struct packed {
        logic            is_load;
        logic [xlen-1:0] data;
    } expect_t;

    logic         clock;
    logic         reset;
    dcache_req_t  request;
    logic         stall;
    dcache_resp_t response;
    mem_req_t     mem_req;
    mem_resp_t    mem_resp;

    integer       seed = 32'he7e2_66cc;
    cache_block_t mem_array [window_lines];
    logic [7:0]   model_bytes [window_bytes];
    expect_t      expect_q [$];
    logic         busy [16];                                 // tag has a load in flight
    int           ret_line [16];
    int           ret_due [16];
    int           cycle, next_tag, line, op_count;
    logic         store_pending, prev_stall;
    dcache_req_t  store_req;
    mem_tag_t     offer, ret, cand;

    dcache #(.n_lines(32), .n_victim(4), .n_mshr(8)) dcache_inst (
        .clock, .reset, .request, .stall, .response, .mem_req, .mem_resp
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // little-endian read of the flat model
    function automatic logic [xlen-1:0] model_load(logic [xlen-1:0] addr, mem_size_t size);
        logic [xlen-1:0] value;
        value = '0;
        for (int b = 0; b < (1 << size); b++) value[8*b +: 8] = model_bytes[addr + b];
        return value;
    endfunction

    function automatic cache_block_t model_line(int idx);
        cache_block_t blk;
        for (int b = 0; b < block_bytes; b++) blk.bytes[b] = model_bytes[idx*block_bytes + b];
        return blk;
    endfunction

    task automatic check_response(dcache_resp_t got, expect_t exp);
        if (exp.is_load && got.data !== exp.data) begin
            report_failure($sformatf("CHECK FAILED at %0t: load returned %h, expected %h",
                                     $time, got.data, exp.data));
        end
    endtask

    task automatic check_writeback(mem_req_t got, cache_block_t exp);
        if (got.data !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: write-back of %h carries %h, expected %h",
                                     $time, got.addr, got.data, exp));
        end
    endtask

    // one request, then an idle slot so nothing new is seen during a stall
    task automatic issue_op(dcache_req_t req, logic expect_hit);
        expect_t exp;
        do @(posedge clock); while (stall);
        request <= req;
        op_count++;
        @(negedge clock);
        exp.is_load = (req.op == MEM_READ);
        exp.data    = exp.is_load ? model_load(req.addr, req.size) : '0;
        expect_q.push_back(exp);
        if (req.op == MEM_WRITE) begin
            store_req     = req;
            store_pending = 1'b1;                            // model takes it on the DUT's edge
        end
        @(posedge clock);
        request <= '0;
        @(negedge clock);
        if (!stall && !response.valid) begin
            report_failure($sformatf("CHECK FAILED at %0t: no response and no stall", $time));
        end
        if (expect_hit && stall) begin
            report_failure($sformatf("CHECK FAILED at %0t: repeated load missed", $time));
        end
    endtask

    function automatic dcache_req_t make_req(mem_op_t op, mem_size_t size, int addr);
        dcache_req_t req;
        req.valid = 1'b1;
        req.op    = op;
        req.size  = size;
        req.addr  = xlen'(addr) & ~((xlen'(1) << size) - 1);
        req.wdata = $random(seed);
        return req;
    endfunction

    // memory model: accept, store, delayed load data
    always @(posedge clock) begin
        if (reset) begin
            mem_resp <= '0;
        end else begin
            if (mem_req.cmd != BUS_NONE && mem_resp.accept != '0) begin
                line = mem_req.addr[11:3];
                if (mem_req.cmd == BUS_STORE) begin
                    check_writeback(mem_req, model_line(line));
                    mem_array[line] = mem_req.data;
                end else begin
                    busy[mem_resp.accept]     = 1'b1;
                    ret_line[mem_resp.accept] = line;
                    ret_due[mem_resp.accept]  = cycle + 2 + rand_below(5);
                end
            end
            if (mem_resp.tag != '0) busy[mem_resp.tag] = 1'b0;
            if (store_pending) begin
                for (int b = 0; b < (1 << store_req.size); b++)
                    model_bytes[store_req.addr + b] = store_req.wdata[8*b +: 8];
                store_pending = 1'b0;
            end
            offer = '0;
            if (rand_below(4) != 0) begin                    // refuse about one in four
                for (int i = 0; i < 15; i++) begin
                    cand = mem_tag_t'((next_tag + i) % 15 + 1);
                    if (offer == '0 && !busy[cand]) offer = cand;
                end
            end
            next_tag = (next_tag + 1) % 15;
            ret = '0;
            for (int t = 1; t < 16; t++) begin
                if (ret == '0 && busy[t] && ret_due[t] <= cycle) ret = mem_tag_t'(t);
            end
            mem_resp <= '{accept: offer,
                          data:   (ret != '0) ? mem_array[ret_line[ret]] : '0,
                          tag:    ret};
        end
        cycle++;
        if (cycle >= max_cycles) begin
            report_failure("timeout: the run did not finish within the cycle limit");
        end
    end

    // responses come back in request order
    always @(negedge clock) begin
        if (!reset) begin
            if (response.valid) begin
                if (expect_q.size() == 0) begin
                    report_failure("a response arrived with no request outstanding");
                end
                check_response(response, expect_q.pop_front());
            end
            if (prev_stall && !stall && !response.valid) begin
                report_failure("a stall ended without a response");
            end
        end
        prev_stall = stall;
    end

    initial begin
        int        kind, base, addr;
        mem_size_t size;
        dcache_req_t req;
        request       = '0;
        mem_resp      = '0;
        reset         = 1'b1;
        store_pending = 1'b0;
        prev_stall    = 1'b0;
        cycle         = 0;
        next_tag      = 0;
        op_count      = 0;
        for (int t = 0; t < 16; t++) begin
            busy[t]    = 1'b0;
            ret_line[t] = 0;
            ret_due[t] = 0;
        end
        for (int i = 0; i < window_lines; i++) begin
            mem_array[i] = {32'(i) ^ 32'h5a5a_0000, 32'(i) * 32'h0101_0033};
            for (int b = 0; b < block_bytes; b++)
                model_bytes[i*block_bytes + b] = mem_array[i].bytes[b];
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (stall || response.valid || mem_req.cmd != BUS_NONE) begin
            report_failure("outputs were active right after reset");
        end

        while (op_count < n_ops - n_sweep_ops) begin
            kind = rand_below(10);
            size = mem_size_t'(rand_below(3));
            base = (rand_below(4) == 0) ? rand_below(window_bytes) : rand_below(512);
            if (kind == 9) begin                             // sized stores merged into one line
                base = (base / block_bytes) * block_bytes;
                issue_op(make_req(MEM_WRITE, BYTE, base + rand_below(8)), 1'b0);
                issue_op(make_req(MEM_WRITE, HALF, base + 2 * rand_below(4)), 1'b0);
                issue_op(make_req(MEM_WRITE, WORD, base + 4 * rand_below(2)), 1'b0);
                issue_op(make_req(MEM_READ, WORD, base), 1'b0);
                issue_op(make_req(MEM_READ, WORD, base + 4), 1'b0);
            end else if (kind < 4) begin
                issue_op(make_req(MEM_WRITE, size, base), 1'b0);
            end else begin
                req = make_req(MEM_READ, size, base);
                issue_op(req, 1'b0);
                if (rand_below(3) == 0) issue_op(req, 1'b1);
            end
        end

        // memory plus cached lines must match the model
        for (addr = 0; addr < window_bytes; addr += 4) begin
            issue_op(make_req(MEM_READ, WORD, addr), 1'b0);
        end
        while (expect_q.size() != 0 || stall) @(posedge clock);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/dcache.sv
`default_nettype none

module dcache
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int n_lines  = 32,
    parameter int n_victim = 4,
    parameter int n_mshr   = 8
) (
    input  logic         clock,
    input  logic         reset,
    input  dcache_req_t  request,
    output logic         stall,
    output dcache_resp_t response,
    output mem_req_t     mem_req,
    input  mem_resp_t    mem_resp
);

    logic         main_hit, victim_hit, forward_hit, miss_alloc;
    cache_block_t main_block, forward_block;
    evict_line_t  victim_line, main_evicted, victim_ejected;
    dcache_req_t  held_request;
    fill_t        fill;

    dcache_ctrl ctrl_inst (
        .clock, .reset, .request, .main_hit, .victim_hit, .forward_hit, .main_block,
        .victim_block(victim_line.block), .forward_block, .fill,
        .stall, .response, .held_request, .miss_alloc
    );

    main_cache #(.n_lines(n_lines)) main_inst (
        .clock, .reset, .request, .accept(!stall), .victim_hit, .victim_line,
        .forward_hit, .forward_block, .fill, .held_request,
        .hit(main_hit), .hit_block(main_block), .evicted(main_evicted)
    );

    victim_cache #(.n_victim(n_victim)) victim_inst (
        .clock, .reset, .request, .accept(!stall), .main_hit, .incoming(main_evicted),
        .hit(victim_hit), .hit_line(victim_line), .ejected(victim_ejected)
    );

    mshr_table #(.n_mshr(n_mshr)) mshr_inst (
        .clock, .reset, .request, .held_request, .miss_alloc, .writeback(victim_ejected),
        .mem_resp, .mem_req, .forward_hit, .forward_block, .fill
    );

endmodule

`default_nettype wire

//--- design/mshr_table.sv
`default_nettype none

module mshr_table
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int n_mshr = 8
) (
    input  logic         clock,
    input  logic         reset,
    input  dcache_req_t  request,
    input  dcache_req_t  held_request,
    input  logic         miss_alloc,
    input  evict_line_t  writeback,
    input  mem_resp_t    mem_resp,
    output mem_req_t     mem_req,
    output logic         forward_hit,
    output cache_block_t forward_block,
    output fill_t        fill
);

    localparam int idx_w = $clog2(n_mshr);

    mshr_entry_t [n_mshr-1:0] entries, entries_n;
    logic [idx_w-1:0]         fwd_idx, fill_idx, issue_idx, free_a, free_b;
    logic [1:0]               free_cnt;                      // saturates at two
    logic                     issue, held_pending;

    always_comb begin
        forward_hit  = 1'b0;
        fwd_idx      = '0;
        fill         = '0;
        fill_idx     = '0;
        held_pending = 1'b0;
        for (int i = 0; i < n_mshr; i++) begin
            if (entries[i].valid && entries[i].op == MEM_WRITE && request.valid
                    && entries[i].addr == request.addr[xlen-1:offset_bits]) begin
                forward_hit = 1'b1;
                fwd_idx     = idx_w'(i);
            end
            if (entries[i].valid && entries[i].addr == held_request.addr[xlen-1:offset_bits])
                held_pending = 1'b1;
            if (entries[i].valid && entries[i].op == MEM_READ && mem_resp.tag != '0
                    && entries[i].tag == mem_resp.tag) begin
                fill     = '{valid: 1'b1, addr: entries[i].addr, block: mem_resp.data};
                fill_idx = idx_w'(i);
            end
        end
    end

    assign forward_block = entries[fwd_idx].block;

    // lowest index first, any write-back before any read
    always_comb begin
        issue     = 1'b0;
        issue_idx = '0;
        free_a    = '0;
        free_b    = '0;
        free_cnt  = '0;
        for (int i = n_mshr - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].tag == '0 && entries[i].op == MEM_READ) begin
                issue     = 1'b1;
                issue_idx = idx_w'(i);
            end
            if (!entries[i].valid) begin
                free_b = free_a;
                free_a = idx_w'(i);
                if (free_cnt != 2'd2) free_cnt = free_cnt + 2'd1;
            end
        end
        for (int i = n_mshr - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].op == MEM_WRITE) begin
                issue     = 1'b1;
                issue_idx = idx_w'(i);
            end
        end
    end

    always_comb begin
        mem_req = '0;
        if (issue) begin
            mem_req.cmd  = (entries[issue_idx].op == MEM_WRITE) ? BUS_STORE : BUS_LOAD;
            mem_req.addr = {entries[issue_idx].addr, {offset_bits{1'b0}}};
            mem_req.data = entries[issue_idx].block;
        end
    end

    always_comb begin
        entries_n = entries;
        if (fill.valid) entries_n[fill_idx].valid = 1'b0;
        if (issue && mem_resp.accept != '0) begin
            if (entries[issue_idx].op == MEM_WRITE) entries_n[issue_idx].valid = 1'b0;
            else entries_n[issue_idx].tag = mem_resp.accept;
        end
        if (forward_hit) entries_n[fwd_idx].valid = 1'b0;    // main cache owns it again
        if (writeback.valid) begin
            entries_n[free_a] = '{valid: 1'b1, op: MEM_WRITE, tag: '0,
                                  addr: writeback.addr, block: writeback.block};
        end
        if (miss_alloc && !held_pending) begin
            entries_n[writeback.valid ? free_b : free_a] =
                '{valid: 1'b1, op: MEM_READ, tag: '0,
                  addr: held_request.addr[xlen-1:offset_bits], block: '0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= entries_n;
        end
    end

    // returned data belongs to an outstanding read, never to a write-back
    assert property (@(posedge clock) disable iff (reset) mem_resp.tag != '0 |-> fill.valid)
        else $error("mshr_table: data tag matched no pending read");

    assert property (@(posedge clock) disable iff (reset)
        free_cnt >= {1'b0, writeback.valid} + {1'b0, miss_alloc})
        else $error("mshr_table: allocation with no free entry");

endmodule

`default_nettype wire

//--- design/victim_cache.sv
`default_nettype none

module victim_cache
    import cache_pkg::*;
#(
    parameter int n_victim = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  dcache_req_t request,
    input  logic        accept,
    input  logic        main_hit,
    input  evict_line_t incoming,
    output logic        hit,
    output evict_line_t hit_line,
    output evict_line_t ejected
);

    localparam int   idx_w   = $clog2(n_victim);
    localparam lru_t lru_max = lru_t'(n_victim - 1);

    victim_line_t [n_victim-1:0] ways, ways_n;
    logic [idx_w-1:0]            hit_idx, slot;
    logic                        take, has_free, dup;
    line_addr_t                  req_line;

    assign req_line = request.addr[xlen-1:offset_bits];
    assign take     = accept && hit && !main_hit;            // line moves to the main cache

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (request.valid && ways[i].valid && ways[i].addr == req_line) begin
                hit     = 1'b1;
                hit_idx = idx_w'(i);
            end
        end
    end

    // store is merged on the way out
    assign hit_line = '{valid: hit,
                        dirty: ways[hit_idx].dirty || request.op == MEM_WRITE,
                        addr:  ways[hit_idx].addr,
                        block: (request.op == MEM_WRITE)
                               ? merge_store(ways[hit_idx].block, request.size,
                                             request.addr[offset_bits-1:0], request.wdata)
                               : ways[hit_idx].block};

    always_comb begin
        slot     = '0;
        has_free = 1'b0;
        for (int i = 0; i < n_victim; i++) begin
            if (ways[i].lru < ways[slot].lru) slot = idx_w'(i);
        end
        for (int i = n_victim - 1; i >= 0; i--) begin     // a way freed by the hit counts as free
            if (!ways[i].valid || (take && hit_idx == idx_w'(i))) begin
                slot     = idx_w'(i);
                has_free = 1'b1;
            end
        end
    end

    assign ejected = '{valid: incoming.valid && !has_free && ways[slot].dirty,
                       dirty: 1'b1, addr: ways[slot].addr, block: ways[slot].block};

    always_comb begin
        ways_n = ways;
        if (take || incoming.valid) begin
            for (int i = 0; i < n_victim; i++) begin
                if (ways[i].lru != '0) ways_n[i].lru = ways[i].lru - 1'b1;
            end
        end
        if (take) ways_n[hit_idx].valid = 1'b0;
        if (incoming.valid) begin
            ways_n[slot] = '{valid: 1'b1, dirty: incoming.dirty, addr: incoming.addr,
                             lru: lru_max, block: incoming.block};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ways <= '0;
        end else begin
            ways <= ways_n;
        end
    end

    always_comb begin
        dup = 1'b0;
        for (int i = 0; i < n_victim; i++) begin
            for (int j = i + 1; j < n_victim; j++) begin
                if (ways[i].valid && ways[j].valid && ways[i].addr == ways[j].addr) dup = 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) !dup)
        else $error("victim_cache: same line held in two ways");

endmodule

`default_nettype wire

//--- design/main_cache.sv
`default_nettype none

module main_cache
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int n_lines = 32
) (
    input  logic         clock,
    input  logic         reset,
    input  dcache_req_t  request,
    input  logic         accept,
    input  logic         victim_hit,
    input  evict_line_t  victim_line,
    input  logic         forward_hit,
    input  cache_block_t forward_block,
    input  fill_t        fill,
    input  dcache_req_t  held_request,
    output logic         hit,
    output cache_block_t hit_block,
    output evict_line_t  evicted
);

    main_line_t [n_lines-1:0] lines, lines_n;
    main_line_t               new_line;
    logic [index_bits-1:0]    req_index, put_index;
    logic [tag_bits-1:0]      req_tag;
    logic                     install;

    assign req_index = request.addr[offset_bits +: index_bits];
    assign req_tag   = request.addr[xlen-1 -: tag_bits];
    assign hit       = request.valid && lines[req_index].valid
                       && (lines[req_index].tag == req_tag);
    assign hit_block = lines[req_index].block;

    always_comb begin
        lines_n   = lines;
        install   = 1'b0;
        put_index = req_index;
        new_line  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag, block: '0};
        if (accept && hit) begin
            if (request.op == MEM_WRITE) begin
                lines_n[req_index].dirty = 1'b1;
                lines_n[req_index].block = merge_store(lines[req_index].block, request.size,
                                                       request.addr[offset_bits-1:0],
                                                       request.wdata);
            end
        end else if (accept && victim_hit) begin             // swap with the victim way
            install        = 1'b1;
            new_line.dirty = victim_line.dirty;
            new_line.block = victim_line.block;
        end else if (accept && forward_hit) begin
            install        = 1'b1;
            new_line.dirty = 1'b1;                           // pulled back out of the write-back queue
            new_line.block = forward_block;
            if (request.op == MEM_WRITE) begin
                new_line.block = merge_store(forward_block, request.size,
                                             request.addr[offset_bits-1:0], request.wdata);
            end
        end else if (fill.valid) begin
            install        = 1'b1;
            put_index      = fill.addr[index_bits-1:0];
            new_line.tag   = fill.addr[xlen-offset_bits-1 -: tag_bits];
            new_line.block = fill.block;
            if (fill.addr == held_request.addr[xlen-1:offset_bits]
                    && held_request.op == MEM_WRITE) begin
                new_line.dirty = 1'b1;                       // store miss completes here
                new_line.block = merge_store(fill.block, held_request.size,
                                             held_request.addr[offset_bits-1:0],
                                             held_request.wdata);
            end
        end
        if (install) begin
            lines_n[put_index] = new_line;
        end
    end

    // the displaced line goes to the victim cache
    assign evicted = '{valid: install && lines[put_index].valid,
                       dirty: lines[put_index].dirty,
                       addr:  {lines[put_index].tag, put_index},
                       block: lines[put_index].block};

    always_ff @(posedge clock) begin
        if (reset) begin
            lines <= '0;
        end else begin
            lines <= lines_n;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  dcache_req_t  request,
    input  logic         main_hit,
    input  logic         victim_hit,
    input  logic         forward_hit,
    input  cache_block_t main_block,
    input  cache_block_t victim_block,
    input  cache_block_t forward_block,
    input  fill_t        fill,
    output logic         stall,
    output dcache_resp_t response,
    output dcache_req_t  held_request,
    output logic         miss_alloc
);

    typedef enum logic {READY, WAIT_FILL} ctrl_state_t;

    ctrl_state_t  state, next_state;
    dcache_resp_t next_response;
    cache_block_t hit_block;
    logic         any_hit, miss, fill_done;

    assign stall     = (state == WAIT_FILL);
    assign any_hit   = main_hit | victim_hit | forward_hit;
    assign miss      = (state == READY) && request.valid && !any_hit;
    assign fill_done = (state == WAIT_FILL) && fill.valid
                       && (fill.addr == held_request.addr[xlen-1:offset_bits]);
    assign hit_block = main_hit ? main_block : (victim_hit ? victim_block : forward_block);

    always_comb begin
        next_state    = state;
        next_response = '0;
        case (state)
            READY: begin
                if (request.valid && any_hit) begin
                    next_response.valid = 1'b1;
                    next_response.data  = extract_load(hit_block, request.size,
                                                       request.addr[offset_bits-1:0]);
                end else if (miss) begin
                    next_state = WAIT_FILL;
                end
            end
            WAIT_FILL: begin
                if (fill_done) begin                         // store data already merged by main cache
                    next_state          = READY;
                    next_response.valid = 1'b1;
                    next_response.data  = extract_load(fill.block, held_request.size,
                                                       held_request.addr[offset_bits-1:0]);
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= READY;
            response   <= '0;
            miss_alloc <= 1'b0;
        end else begin
            state      <= next_state;
            response   <= next_response;
            miss_alloc <= miss;                              // MSHR sees the latched request
        end
    end

    always_ff @(posedge clock) begin
        if (miss) begin
            held_request <= request;
        end
    end

    // a line lives in exactly one of main, victim or write-back queue
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({main_hit, victim_hit, forward_hit}))
        else $error("dcache_ctrl: more than one hit source");

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    import cache_pkg::*;

    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_t;

    typedef logic [3:0] mem_tag_t;                           // zero means no transaction

    typedef struct packed {
        bus_cmd_t        cmd;
        logic [xlen-1:0] addr;
        cache_block_t    data;
    } mem_req_t;

    // accept comes back in the same cycle, data and tag later
    typedef struct packed {
        mem_tag_t     accept;
        cache_block_t data;
        mem_tag_t     tag;
    } mem_resp_t;

    typedef struct packed {
        logic         valid;
        mem_op_t      op;                                    // MEM_WRITE is a write-back
        mem_tag_t     tag;                                   // zero until memory accepts
        line_addr_t   addr;
        cache_block_t block;
    } mshr_entry_t;

    typedef struct packed {
        logic         valid;
        line_addr_t   addr;
        cache_block_t block;
    } fill_t;

endpackage

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int xlen        = 32;
    localparam int block_bytes = 8;
    localparam int offset_bits = $clog2(block_bytes);
    localparam int index_bits  = 5;                          // 32 main cache lines
    localparam int tag_bits    = xlen - index_bits - offset_bits;

    typedef logic [xlen-offset_bits-1:0] line_addr_t;        // byte offset stripped
    typedef logic [3:0] lru_t;

    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;

    typedef union packed {
        logic [block_bytes-1:0][7:0]    bytes;
        logic [block_bytes/2-1:0][15:0] halves;
        logic [block_bytes/4-1:0][31:0] words;
    } cache_block_t;

    typedef struct packed {
        logic                valid, dirty;
        logic [tag_bits-1:0] tag;
        cache_block_t        block;
    } main_line_t;

    typedef struct packed {
        logic         valid, dirty;
        line_addr_t   addr;
        lru_t         lru;                                   // zero is the next to go
        cache_block_t block;
    } victim_line_t;

    typedef struct packed {
        logic            valid;
        mem_op_t         op;
        mem_size_t       size;
        logic [xlen-1:0] addr, wdata;
    } dcache_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;                               // zero-extended load value
    } dcache_resp_t;

    typedef struct packed {
        logic         valid, dirty;
        line_addr_t   addr;
        cache_block_t block;
    } evict_line_t;

    function automatic cache_block_t merge_store(cache_block_t blk, mem_size_t size,
                                                 logic [offset_bits-1:0] offset,
                                                 logic [xlen-1:0] data);
        cache_block_t result;
        result = blk;
        case (size)
            BYTE:    result.bytes[offset] = data[7:0];
            HALF:    result.halves[offset[2:1]] = data[15:0];
            default: result.words[offset[2]] = data;
        endcase
        return result;
    endfunction

    function automatic logic [xlen-1:0] extract_load(cache_block_t blk, mem_size_t size,
                                                     logic [offset_bits-1:0] offset);
        case (size)
            BYTE:    return xlen'(blk.bytes[offset]);
            HALF:    return xlen'(blk.halves[offset[2:1]]);
            default: return blk.words[offset[2]];
        endcase
    endfunction

endpackage

`default_nettype wire
